// File: tm1638_pkg.sv
// shared types and TM1638 opcodes; opcodes assume the LED&KEY shield's bus command set
package tm1638_pkg;

	typedef logic [7:0] tm_byte_t;		// one byte on the shield bus
	typedef logic [2:0] digit_idx_t;	// digit or LED position 0-7
	typedef logic [19:0] wait_cnt_t;	// gap counter in clock cycles

	// data command, write with auto-increment
	localparam tm_byte_t CMD_AUTO_INC = 8'h40;
	// data command, read the key scan bytes
	localparam tm_byte_t CMD_READ_KEYS = 8'h42;
	// data command, write to one fixed address
	localparam tm_byte_t CMD_FIXED_ADDR = 8'h44;
	// display control, on with pulse width 14/16
	localparam tm_byte_t CMD_DISPLAY_ON = 8'h8F;
	// address command for address 0
	localparam tm_byte_t CMD_ADDR_BASE = 8'hC0;

	typedef enum logic [2:0] {
		ST_RESET,	// first cycle out of reset
		ST_INIT,	// start of the power-up sequence
		ST_IDLE,	// waiting for a host command
		ST_FRAME,	// strobe low, write bytes
		ST_READ,	// strobe low, key bytes in
		ST_GAP		// strobe high, timer running
	} seq_state_t;

endpackage

// File: tm_byte_if.sv
// single-byte handshake, en is one cycle and only honoured while idle is high
`timescale 1ns/1ps

interface tm_byte_if;

	logic en;				// start one byte
	tm1638_pkg::tm_byte_t tx_byte;		// byte to write
	logic rd;				// 1 = read a byte instead
	tm1638_pkg::tm_byte_t rx_byte;		// last byte read, valid once idle rises
	logic idle;				// serializer ready

	modport seq (
		output en,
		output tx_byte,
		output rd,
		input rx_byte,
		input idle
	);

	modport ser (
		input en,
		input tx_byte,
		input rd,
		output rx_byte,
		output idle
	);

endinterface

// File: tm1638_serial.sv
// byte serializer, LSB first, 16*BIT_HALF_CYCLES clocks per byte; needs BIT_HALF_CYCLES >= 1
`timescale 1ns/1ps

module tm1638_serial #(
	parameter int BIT_HALF_CYCLES = 6
) (
	input logic i_clk,
	input logic rst_n,
	tm_byte_if.ser bus,
	output logic o_tm_clk,
	output logic o_dio,
	output logic o_dio_oe,
	input logic i_dio
);

	localparam int HALF_W = (BIT_HALF_CYCLES > 1) ? $clog2(BIT_HALF_CYCLES) : 1;
	localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(BIT_HALF_CYCLES - 1);

	logic [HALF_W-1:0] half_cnt;		// cycles within one clock half
	logic [3:0] phase;			// which half period, 0..15
	logic rd_q;				// current byte is a read
	tm1638_pkg::tm_byte_t tx_shift;
	tm1638_pkg::tm_byte_t rx_shift;

	logic start;
	logic half_end;
	logic rise;
	logic fall;

	assign start = bus.en && bus.idle;
	assign half_end = !bus.idle && (half_cnt == HALF_LAST);
	assign rise = half_end && !phase[0];	// even phase ends low, clock goes high
	assign fall = half_end && phase[0] && (phase != 4'd15);

	assign o_dio = tx_shift[0];
	assign bus.rx_byte = rx_shift;

	// pin and handshake control
	always_ff @(posedge i_clk) begin
		if (!rst_n) begin
			bus.idle <= 1'b1;
			half_cnt <= '0;
			phase <= '0;
			o_tm_clk <= 1'b1;			// shield clock idles high
			o_dio_oe <= 1'b0;
			rd_q <= 1'b0;
		end else if (start) begin
			bus.idle <= 1'b0;
			half_cnt <= '0;
			phase <= '0;
			o_tm_clk <= 1'b0;			// first bit is set up while low
			rd_q <= bus.rd;
			o_dio_oe <= !bus.rd;		// line released for reads
		end else if (!bus.idle) begin
			if (half_end) begin
				half_cnt <= '0;
				if (phase == 4'd15) begin
					bus.idle <= 1'b1;	// last rising edge done, clock stays high
				end else begin
					phase <= phase + 4'd1;
					o_tm_clk <= !o_tm_clk;
				end
			end else begin
				half_cnt <= half_cnt + 1'b1;
			end
		end
	end

	// shift registers
	always_ff @(posedge i_clk) begin
		if (start) begin
			tx_shift <= bus.tx_byte;
		end else if (fall) begin
			tx_shift <= tx_shift >> 1;	// next bit while clock low
		end

		if (rise && rd_q) begin
			rx_shift <= {i_dio, rx_shift[7:1]};	// LSB arrives first
		end
	end

endmodule

// File: tm1638_wait_timer.sv
// strobe gap timer, GAP_USEC*CLOCK_FREQ_MHZ must fit 20 bits; a zero product ends after one cycle
`timescale 1ns/1ps

module tm1638_wait_timer #(
	parameter int CLOCK_FREQ_MHZ = 12,
	parameter int GAP_USEC = 2
) (
	input logic i_clk,
	input logic rst_n,
	input logic i_start,
	output logic o_done
);

	localparam tm1638_pkg::wait_cnt_t LOAD =
		tm1638_pkg::wait_cnt_t'(GAP_USEC * CLOCK_FREQ_MHZ);

	tm1638_pkg::wait_cnt_t cnt;		// cycles left

	always_ff @(posedge i_clk) begin
		if (!rst_n) begin
			cnt <= '0;
			o_done <= 1'b1;			// stopped counts as expired
		end else if (i_start) begin
			cnt <= LOAD;
			o_done <= 1'b0;
		end else if (!o_done) begin
			cnt <= cnt - 1'b1;
			if (cnt <= tm1638_pkg::wait_cnt_t'(1)) begin
				o_done <= 1'b1;		// LOAD cycles after start
			end
		end
	end

endmodule

// File: tm1638_sequencer.sv
// frame builder; key bytes follow the read command with no extra wait, enables while busy are dropped
`timescale 1ns/1ps

module tm1638_sequencer (
	input logic i_clk,
	input logic rst_n,
	input logic i_en_raw,
	input tm1638_pkg::tm_byte_t i_raw_data,
	input logic i_en_led,
	input tm1638_pkg::tm_byte_t i_led_state,
	input logic i_en_seg7,
	input tm1638_pkg::digit_idx_t i_seg7_idx,
	input tm1638_pkg::tm_byte_t i_seg7_state,
	input logic i_en_buttons,
	output tm1638_pkg::tm_byte_t o_button_state,
	output logic o_tm_stb,
	output logic o_idle,
	tm_byte_if.seq bus,
	output logic o_gap_start,
	input logic i_gap_done
);

	typedef enum logic [2:0] {
		JOB_INIT,
		JOB_LED,
		JOB_SEG7,
		JOB_RAW,
		JOB_KEYS
	} job_t;

	tm1638_pkg::seq_state_t state;
	job_t job;
	logic [3:0] frame_idx;			// frame within the job
	logic [4:0] byte_idx;			// bytes already issued in this frame

	tm1638_pkg::tm_byte_t raw_q;
	tm1638_pkg::tm_byte_t led_q;
	tm1638_pkg::digit_idx_t seg_idx_q;
	tm1638_pkg::tm_byte_t seg_q;
	tm1638_pkg::tm_byte_t key_acc;	// buttons gathered during a read

	logic [4:0] frame_len;
	logic [3:0] last_frame;
	tm1638_pkg::tm_byte_t frame_byte;
	tm1638_pkg::digit_idx_t led_idx;
	logic [1:0] key_k;

	logic ser_ready;
	logic gap_ready;
	logic accept;
	logic issue_wr;
	logic issue_rd;
	logic capture_key;

	// en and start are registered, so skip the cycle right after each pulse
	assign ser_ready = bus.idle && !bus.en;
	assign gap_ready = i_gap_done && !o_gap_start;
	assign accept = (state == tm1638_pkg::ST_IDLE) &&
		(i_en_raw || i_en_led || i_en_seg7 || i_en_buttons);
	assign issue_wr = (state == tm1638_pkg::ST_FRAME) && ser_ready && (byte_idx < frame_len);
	assign issue_rd = (state == tm1638_pkg::ST_READ) && ser_ready && (byte_idx < 5'd4);
	assign capture_key = (state == tm1638_pkg::ST_READ) && ser_ready && (byte_idx != 5'd0);

	assign led_idx = tm1638_pkg::digit_idx_t'(frame_idx - 4'd1);	// frame 0 is the mode cmd
	assign key_k = 2'(byte_idx - 5'd1);

	// frame contents per job
	always_comb begin
		frame_len = 5'd1;
		last_frame = 4'd0;
		frame_byte = tm1638_pkg::CMD_READ_KEYS;
		case (job)
			JOB_INIT: begin
				last_frame = 4'd2;
				if (frame_idx == 4'd0) begin
					frame_byte = tm1638_pkg::CMD_DISPLAY_ON;
				end else if (frame_idx == 4'd1) begin
					frame_byte = tm1638_pkg::CMD_AUTO_INC;
				end else begin
					frame_len = 5'd17;		// address plus 16 cleared bytes
					frame_byte = (byte_idx == 5'd0) ? tm1638_pkg::CMD_ADDR_BASE : 8'h00;
				end
			end
			JOB_LED: begin
				last_frame = 4'd8;
				if (frame_idx == 4'd0) begin
					frame_byte = tm1638_pkg::CMD_FIXED_ADDR;
				end else begin
					frame_len = 5'd2;
					frame_byte = (byte_idx == 5'd0) ?
						tm1638_pkg::CMD_ADDR_BASE + {4'd0, led_idx, 1'b1} :	// odd address
						{7'd0, led_q[led_idx]};
				end
			end
			JOB_SEG7: begin
				last_frame = 4'd1;
				if (frame_idx == 4'd0) begin
					frame_byte = tm1638_pkg::CMD_FIXED_ADDR;
				end else begin
					frame_len = 5'd2;
					frame_byte = (byte_idx == 5'd0) ?
						tm1638_pkg::CMD_ADDR_BASE + {4'd0, seg_idx_q, 1'b0} :	// even address
						seg_q;
				end
			end
			JOB_RAW: frame_byte = raw_q;
			default: frame_byte = tm1638_pkg::CMD_READ_KEYS;	// reads follow in ST_READ
		endcase
	end

	// FSM and handshake
	always_ff @(posedge i_clk) begin
		if (!rst_n) begin
			state <= tm1638_pkg::ST_RESET;
			job <= JOB_INIT;
			frame_idx <= '0;
			byte_idx <= '0;
			o_tm_stb <= 1'b1;
			o_idle <= 1'b0;
			o_button_state <= '0;
			o_gap_start <= 1'b0;
			bus.en <= 1'b0;
			bus.rd <= 1'b0;
		end else begin
			bus.en <= 1'b0;
			o_gap_start <= 1'b0;
			case (state)
				tm1638_pkg::ST_RESET: begin
					job <= JOB_INIT;
					frame_idx <= '0;
					byte_idx <= '0;
					state <= tm1638_pkg::ST_INIT;
				end
				tm1638_pkg::ST_INIT: begin
					if (ser_ready && gap_ready) begin
						o_tm_stb <= 1'b0;
						state <= tm1638_pkg::ST_FRAME;
					end
				end
				tm1638_pkg::ST_IDLE: begin
					if (accept) begin
						o_idle <= 1'b0;
						o_tm_stb <= 1'b0;
						frame_idx <= '0;
						byte_idx <= '0;
						state <= tm1638_pkg::ST_FRAME;
						if (i_en_raw) job <= JOB_RAW;		// fixed priority
						else if (i_en_led) job <= JOB_LED;
						else if (i_en_seg7) job <= JOB_SEG7;
						else job <= JOB_KEYS;
					end
				end
				tm1638_pkg::ST_FRAME: begin
					if (issue_wr) begin
						bus.en <= 1'b1;
						bus.rd <= 1'b0;
						byte_idx <= byte_idx + 5'd1;
					end else if (ser_ready) begin
						if (job == JOB_KEYS) begin
							byte_idx <= '0;		// strobe stays low for the reads
							state <= tm1638_pkg::ST_READ;
						end else begin
							o_tm_stb <= 1'b1;
							o_gap_start <= 1'b1;
							state <= tm1638_pkg::ST_GAP;
						end
					end
				end
				tm1638_pkg::ST_READ: begin
					if (issue_rd) begin
						bus.en <= 1'b1;
						bus.rd <= 1'b1;
						byte_idx <= byte_idx + 5'd1;
					end else if (ser_ready) begin
						o_tm_stb <= 1'b1;
						o_gap_start <= 1'b1;
						state <= tm1638_pkg::ST_GAP;
					end
				end
				tm1638_pkg::ST_GAP: begin
					if (gap_ready) begin
						byte_idx <= '0;
						if (frame_idx == last_frame) begin
							o_idle <= 1'b1;
							state <= tm1638_pkg::ST_IDLE;
							if (job == JOB_KEYS) o_button_state <= key_acc;
						end else begin
							frame_idx <= frame_idx + 4'd1;
							o_tm_stb <= 1'b0;
							state <= tm1638_pkg::ST_FRAME;
						end
					end
				end
				default: state <= tm1638_pkg::ST_RESET;
			endcase
		end
	end

	// command payload and key capture
	always_ff @(posedge i_clk) begin
		if (accept) begin
			raw_q <= i_raw_data;
			led_q <= i_led_state;
			seg_idx_q <= i_seg7_idx;
			seg_q <= i_seg7_state;
			key_acc <= '0;
		end
		if (issue_wr) bus.tx_byte <= frame_byte;
		if (capture_key) begin
			key_acc[{1'b0, key_k}] <= bus.rx_byte[0];	// button k
			key_acc[{1'b1, key_k}] <= bus.rx_byte[4];	// button k+4
		end
	end

endmodule

// File: tm1638_led_key.sv
// LED&KEY shield driver top; io_tm1638_data needs an external pull-up, one shield only
`timescale 1ns/1ps

module tm1638_led_key #(
	parameter int CLOCK_FREQ_MHZ = 12,
	parameter int BIT_HALF_CYCLES = 6,
	parameter int GAP_USEC = 2
) (
	input logic i_clk,
	input logic rst_n,
	input logic i_en_raw,
	input tm1638_pkg::tm_byte_t i_raw_data,
	input logic i_en_led,
	input tm1638_pkg::tm_byte_t i_led_state,
	input logic i_en_seg7,
	input tm1638_pkg::digit_idx_t i_seg7_idx,
	input tm1638_pkg::tm_byte_t i_seg7_state,
	input logic i_en_buttons,
	output tm1638_pkg::tm_byte_t o_button_state,
	output logic o_tm1638_clk,
	output logic o_tm1638_stb,
	output logic o_idle,
	inout wire io_tm1638_data
);

	logic dio_out;
	logic dio_oe;
	logic gap_start;
	logic gap_done;

	tm_byte_if byte_bus ();

	tm1638_sequencer sequencer_inst (
		.i_clk(i_clk),
		.rst_n(rst_n),
		.i_en_raw(i_en_raw),
		.i_raw_data(i_raw_data),
		.i_en_led(i_en_led),
		.i_led_state(i_led_state),
		.i_en_seg7(i_en_seg7),
		.i_seg7_idx(i_seg7_idx),
		.i_seg7_state(i_seg7_state),
		.i_en_buttons(i_en_buttons),
		.o_button_state(o_button_state),
		.o_tm_stb(o_tm1638_stb),
		.o_idle(o_idle),
		.bus(byte_bus.seq),
		.o_gap_start(gap_start),
		.i_gap_done(gap_done)
	);

	tm1638_serial #(
		.BIT_HALF_CYCLES(BIT_HALF_CYCLES)
	) serial_inst (
		.i_clk(i_clk),
		.rst_n(rst_n),
		.bus(byte_bus.ser),
		.o_tm_clk(o_tm1638_clk),
		.o_dio(dio_out),
		.o_dio_oe(dio_oe),
		.i_dio(io_tm1638_data)
	);

	tm1638_wait_timer #(
		.CLOCK_FREQ_MHZ(CLOCK_FREQ_MHZ),
		.GAP_USEC(GAP_USEC)
	) timer_inst (
		.i_clk(i_clk),
		.rst_n(rst_n),
		.i_start(gap_start),
		.o_done(gap_done)
	);

	assign io_tm1638_data = dio_oe ? dio_out : 1'bz;	// released for key reads

endmodule

// File: tb_tm1638_led_key_sva.sv
// bus protocol checks bound into tm1638_led_key; fail_cnt is read by the testbench at the end
`timescale 1ns/1ps

module tb_tm1638_led_key_sva (
	input logic i_clk,
	input logic rst_n,
	input logic i_stb,
	input logic i_tm_clk,
	input logic i_dio_oe,
	input logic i_rd,
	input logic [7:0] i_tx_byte,
	input logic i_idle,
	input logic i_en_any
);

	int fail_cnt = 0;

	// no shield clock edges between frames
	clk_quiet_between_frames: assert property (@(posedge i_clk) disable iff (!rst_n)
		(i_stb && $past(i_stb)) |-> $stable(i_tm_clk))
	else begin
		$error("shield clock toggled while the strobe was high");
		fail_cnt++;
	end

	// line released only after the key read command
	oe_falls_in_read: assert property (@(posedge i_clk) disable iff (!rst_n)
		$fell(i_dio_oe) |-> (!i_stb && i_rd && i_tx_byte == 8'h42))
	else begin
		$error("data output enable fell outside a key read frame");
		fail_cnt++;
	end

	// a byte is still shifting while the shield clock is low
	idle_low_while_shifting: assert property (@(posedge i_clk) disable iff (!rst_n)
		!i_tm_clk |-> !i_idle)
	else begin
		$error("o_idle high while a byte was being shifted");
		fail_cnt++;
	end

	accept_drops_idle: assert property (@(posedge i_clk) disable iff (!rst_n)
		(i_idle && i_en_any) |=> !i_idle)
	else begin
		$error("o_idle did not fall after an accepted command");
		fail_cnt++;
	end

endmodule

// File: tb_tm1638_model.sv
// one-shield model, records bytes seen while STB is low and drives key bytes LSB first on reads
`timescale 1ns/1ps

module tb_tm1638_model (
	input logic i_tm_clk,
	input logic i_tm_stb,
	inout wire io_dio,
	input logic [31:0] i_keys		// key byte k sits at bits 8k+7..8k
);

	tm1638_pkg::tm_byte_t frame_bytes[$];	// finished frames, back to back
	int frame_lens[$];			// byte count of each finished frame

	tm1638_pkg::tm_byte_t cur_bytes[$];	// bytes of the open frame
	tm1638_pkg::tm_byte_t shift_in;
	int bit_cnt;
	int rd_bit;				// key bit to drive next
	logic reading;				// read command seen in this frame
	logic drive_en;
	logic drive_val;

	assign io_dio = drive_en ? drive_val : 1'bz;

	initial begin
		shift_in = '0;
		bit_cnt = 0;
		rd_bit = 0;
		reading = 1'b0;
		drive_en = 1'b0;
		drive_val = 1'b1;
	end

	// frame opens
	always @(negedge i_tm_stb) begin
		cur_bytes.delete();
		bit_cnt = 0;
		rd_bit = 0;
		reading = 1'b0;
		drive_en = 1'b0;
	end

	// frame closes, hand it over
	always @(posedge i_tm_stb) begin
		drive_en = 1'b0;
		reading = 1'b0;
		if (cur_bytes.size() > 0) begin
			frame_lens.push_back(cur_bytes.size());
			foreach (cur_bytes[i]) begin
				frame_bytes.push_back(cur_bytes[i]);
			end
			cur_bytes.delete();
		end
	end

	// written bits latch on the rising shield clock
	always @(posedge i_tm_clk) begin
		if (!i_tm_stb && reading) begin
			rd_bit = rd_bit + 1;		// DUT took the bit on this edge
		end else if (!i_tm_stb) begin
			shift_in = {io_dio, shift_in[7:1]};
			bit_cnt = bit_cnt + 1;
			if (bit_cnt == 8) begin
				bit_cnt = 0;
				cur_bytes.push_back(shift_in);
				if (cur_bytes.size() == 1 && shift_in == 8'h42) begin
					reading = 1'b1;		// key bytes follow
				end
			end
		end
	end

	// key bits set up while the clock is low
	always @(negedge i_tm_clk) begin
		if (!i_tm_stb && reading && rd_bit < 32) begin
			drive_val = i_keys[rd_bit];
			drive_en = 1'b1;
		end
	end

endmodule

// File: tb_tm1638_led_key.sv
// testbench for tm1638_led_key, small timing parameters, one model shield with a pull-up on DIO
`timescale 1ns/1ps

module tb_tm1638_led_key;

	localparam int CLOCK_FREQ_MHZ = 2;
	localparam int BIT_HALF_CYCLES = 2;
	localparam int GAP_USEC = 1;
	localparam int CLK_PERIOD = 8;
	// longest frame is address plus 16 bytes with a few handshake cycles per byte
	localparam int WORST_FRAME = 17 * (16 * BIT_HALF_CYCLES + 3) + GAP_USEC * CLOCK_FREQ_MHZ + 4;
	localparam int WATCHDOG_NS = 40 * WORST_FRAME * CLK_PERIOD;

	localparam int KIND_INIT = 0;
	localparam int KIND_LED = 1;
	localparam int KIND_SEG7 = 2;
	localparam int KIND_RAW = 3;
	localparam int KIND_KEYS = 4;

	logic i_clk;
	logic rst_n;
	logic i_en_raw;
	tm1638_pkg::tm_byte_t i_raw_data;
	logic i_en_led;
	tm1638_pkg::tm_byte_t i_led_state;
	logic i_en_seg7;
	tm1638_pkg::digit_idx_t i_seg7_idx;
	tm1638_pkg::tm_byte_t i_seg7_state;
	logic i_en_buttons;
	tm1638_pkg::tm_byte_t o_button_state;
	logic o_tm1638_clk;
	logic o_tm1638_stb;
	logic o_idle;
	wire io_tm1638_data;
	logic [31:0] model_keys;

	tm1638_pkg::tm_byte_t exp_bytes[$];	// expected frames, back to back
	int exp_lens[$];
	tm1638_pkg::tm_byte_t exp_buttons;
	logic check_buttons;
	logic compare_req;			// stimulus to compare process
	string cur_test;
	int test_errs;
	int total_errs;
	int tests_run;
	int tests_failed;
	integer seed;

	pullup (io_tm1638_data);

	tm1638_led_key #(
		.CLOCK_FREQ_MHZ(CLOCK_FREQ_MHZ),
		.BIT_HALF_CYCLES(BIT_HALF_CYCLES),
		.GAP_USEC(GAP_USEC)
	) tm1638_led_key_inst (
		.i_clk(i_clk),
		.rst_n(rst_n),
		.i_en_raw(i_en_raw),
		.i_raw_data(i_raw_data),
		.i_en_led(i_en_led),
		.i_led_state(i_led_state),
		.i_en_seg7(i_en_seg7),
		.i_seg7_idx(i_seg7_idx),
		.i_seg7_state(i_seg7_state),
		.i_en_buttons(i_en_buttons),
		.o_button_state(o_button_state),
		.o_tm1638_clk(o_tm1638_clk),
		.o_tm1638_stb(o_tm1638_stb),
		.o_idle(o_idle),
		.io_tm1638_data(io_tm1638_data)
	);

	tb_tm1638_model model_inst (
		.i_tm_clk(o_tm1638_clk),
		.i_tm_stb(o_tm1638_stb),
		.io_dio(io_tm1638_data),
		.i_keys(model_keys)
	);

	bind tm1638_led_key tb_tm1638_led_key_sva sva_inst (
		.i_clk(i_clk),
		.rst_n(rst_n),
		.i_stb(o_tm1638_stb),
		.i_tm_clk(o_tm1638_clk),
		.i_dio_oe(dio_oe),
		.i_rd(byte_bus.rd),
		.i_tx_byte(byte_bus.tx_byte),
		.i_idle(o_idle),
		.i_en_any(i_en_raw || i_en_led || i_en_seg7 || i_en_buttons)
	);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	// frames the shield must see for one command
	function automatic void expected_frames(input int kind, input tm1638_pkg::tm_byte_t data,
		input tm1638_pkg::digit_idx_t idx);
		int i;
		case (kind)
			KIND_INIT: begin
				exp_lens.push_back(1);
				exp_bytes.push_back(8'h8F);		// display on, full brightness
				exp_lens.push_back(1);
				exp_bytes.push_back(8'h40);
				exp_lens.push_back(17);
				exp_bytes.push_back(8'hC0);
				for (i = 0; i < 16; i++) begin
					exp_bytes.push_back(8'h00);
				end
			end
			KIND_LED: begin
				exp_lens.push_back(1);
				exp_bytes.push_back(8'h44);
				for (i = 0; i < 8; i++) begin
					exp_lens.push_back(2);
					exp_bytes.push_back(tm1638_pkg::tm_byte_t'(8'hC0 + 2 * i + 1));
					exp_bytes.push_back(tm1638_pkg::tm_byte_t'(data[i]));
				end
			end
			KIND_SEG7: begin
				exp_lens.push_back(1);
				exp_bytes.push_back(8'h44);
				exp_lens.push_back(2);
				exp_bytes.push_back(tm1638_pkg::tm_byte_t'(8'hC0 + 2 * idx));
				exp_bytes.push_back(data);
			end
			KIND_RAW: begin
				exp_lens.push_back(1);
				exp_bytes.push_back(data);
			end
			default: begin
				exp_lens.push_back(1);
				exp_bytes.push_back(8'h42);	// key bytes are reads, not recorded
			end
		endcase
	endfunction

	function automatic tm1638_pkg::tm_byte_t expected_buttons(input logic [31:0] keys);
		tm1638_pkg::tm_byte_t res;
		int k;
		for (k = 0; k < 4; k++) begin
			res[k] = keys[8 * k];		// bit 0 of key byte k
			res[k + 4] = keys[8 * k + 4];	// bit 4 of key byte k
		end
		return res;
	endfunction

	task automatic pulse_enable(input int kind, input tm1638_pkg::tm_byte_t data,
		input tm1638_pkg::digit_idx_t idx);
		case (kind)
			KIND_LED: begin
				i_led_state = data;
				i_en_led = 1'b1;
			end
			KIND_SEG7: begin
				i_seg7_idx = idx;
				i_seg7_state = data;
				i_en_seg7 = 1'b1;
			end
			KIND_RAW: begin
				i_raw_data = data;
				i_en_raw = 1'b1;
			end
			default: i_en_buttons = 1'b1;
		endcase
		@(posedge i_clk);
		#1;
		i_en_raw = 1'b0;
		i_en_led = 1'b0;
		i_en_seg7 = 1'b0;
		i_en_buttons = 1'b0;
	endtask

	task automatic wait_idle();
		do begin
			@(posedge i_clk);
			#1;
		end while (!o_idle);
	endtask

	task automatic compare_frames();
		int f;
		int b;
		int got_len;
		int exp_len;
		tm1638_pkg::tm_byte_t got_b;
		tm1638_pkg::tm_byte_t exp_b;
		f = 0;
		while (exp_lens.size() > 0 && model_inst.frame_lens.size() > 0) begin
			got_len = model_inst.frame_lens.pop_front();
			exp_len = exp_lens.pop_front();
			assert (got_len == exp_len) else begin
				$display("frame %0d has %0d bytes where %0d were expected", f, got_len, exp_len);
				test_errs++;
			end
			for (b = 0; b < got_len && b < exp_len; b++) begin
				got_b = model_inst.frame_bytes.pop_front();
				exp_b = exp_bytes.pop_front();
				assert (got_b == exp_b) else begin
					$display("[ERROR] frame %0d byte %0d io_tm1638_data got 0x%02h expected 0x%02h",
						f, b, got_b, exp_b);
					test_errs++;
				end
			end
			repeat (got_len - b) got_b = model_inst.frame_bytes.pop_front();
			repeat (exp_len - b) exp_b = exp_bytes.pop_front();
			f++;
		end
		assert (model_inst.frame_lens.size() == 0) else begin
			$display("%0d extra frames appeared on the bus", model_inst.frame_lens.size());
			test_errs++;
		end
		assert (exp_lens.size() == 0) else begin
			$display("%0d expected frames never appeared on the bus", exp_lens.size());
			test_errs++;
		end
		model_inst.frame_lens.delete();
		model_inst.frame_bytes.delete();
		exp_lens.delete();
		exp_bytes.delete();
	endtask

	// compare process
	initial begin
		forever begin
			wait (compare_req);
			compare_frames();
			if (check_buttons) begin
				assert (o_button_state == exp_buttons) else begin
					$display("[ERROR] o_button_state got 0x%02h expected 0x%02h",
						o_button_state, exp_buttons);
					test_errs++;
				end
			end
			tests_run++;
			if (test_errs != 0) tests_failed++;
			total_errs += test_errs;
			$display("test %0s: %0s, %0d errors", cur_test, (test_errs != 0) ? "FAIL" : "ok",
				test_errs);
			compare_req = 1'b0;
		end
	end

	task automatic run_test(input string name, input int kind, input tm1638_pkg::tm_byte_t data,
		input tm1638_pkg::digit_idx_t idx);
		cur_test = name;
		test_errs = 0;
		check_buttons = (kind == KIND_KEYS);
		exp_buttons = expected_buttons(model_keys);
		expected_frames(kind, data, idx);
		pulse_enable(kind, data, idx);
		wait_idle();
		compare_req = 1'b1;
		wait (!compare_req);
	endtask

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: commands not finished after %0d ns", WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		int n;
		tm1638_pkg::tm_byte_t rnd_data;
		seed = 32'hf605_1825;
		i_clk = 1'b0;
		rst_n = 1'b0;
		i_en_raw = 1'b0;
		i_raw_data = '0;
		i_en_led = 1'b0;
		i_led_state = '0;
		i_en_seg7 = 1'b0;
		i_seg7_idx = '0;
		i_seg7_state = '0;
		i_en_buttons = 1'b0;
		model_keys = '0;
		compare_req = 1'b0;
		check_buttons = 1'b0;
		exp_buttons = '0;
		test_errs = 0;
		total_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (10) @(posedge i_clk);
		#1;
		rst_n = 1'b1;

		cur_test = "init";				// power-up frames, no command
		expected_frames(KIND_INIT, 8'h00, 3'd0);
		wait_idle();
		compare_req = 1'b1;
		wait (!compare_req);

		for (n = 0; n < 2; n++) begin
			run_test("led update", KIND_LED, tm1638_pkg::tm_byte_t'($random(seed)), 3'd0);
		end
		for (n = 0; n < 3; n++) begin
			rnd_data = tm1638_pkg::tm_byte_t'($random(seed));
			run_test("digit update", KIND_SEG7, rnd_data,
				tm1638_pkg::digit_idx_t'($random(seed)));
		end
		for (n = 0; n < 2; n++) begin
			run_test("raw byte", KIND_RAW, tm1638_pkg::tm_byte_t'($random(seed)), 3'd0);
		end
		for (n = 0; n < 2; n++) begin
			model_keys = $random(seed);
			run_test("button read", KIND_KEYS, 8'h00, 3'd0);
		end

		// second enable lands while the raw frame is still running
		cur_test = "busy enable";
		test_errs = 0;
		check_buttons = 1'b0;
		rnd_data = tm1638_pkg::tm_byte_t'($random(seed));
		expected_frames(KIND_RAW, rnd_data, 3'd0);
		pulse_enable(KIND_RAW, rnd_data, 3'd0);
		repeat (3) @(posedge i_clk);
		#1;
		assert (!o_idle) else begin
			$display("o_idle was high while the raw command was still running");
			test_errs++;
		end
		pulse_enable(KIND_LED, tm1638_pkg::tm_byte_t'($random(seed)), 3'd0);
		wait_idle();
		compare_req = 1'b1;
		wait (!compare_req);

		$display("summary: %0d tests, %0d failed, %0d errors, %0d assertion failures",
			tests_run, tests_failed, total_errs, tm1638_led_key_inst.sva_inst.fail_cnt);
		if (total_errs == 0 && tm1638_led_key_inst.sva_inst.fail_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: tb.f
tm1638_pkg.sv
tm_byte_if.sv
tm1638_serial.sv
tm1638_wait_timer.sv
tm1638_sequencer.sv
tm1638_led_key.sv
tb_tm1638_led_key_sva.sv
tb_tm1638_model.sv
tb_tm1638_led_key.sv

// File: Bender.yml
package:
  name: tm1638_led_key

sources:
  - files:
      - tm1638_pkg.sv
      - tm_byte_if.sv
      - tm1638_serial.sv
      - tm1638_wait_timer.sv
      - tm1638_sequencer.sv
      - tm1638_led_key.sv
  - target: test
    files:
      - tb_tm1638_led_key_sva.sv
      - tb_tm1638_model.sv
      - tb_tm1638_led_key.sv
